// File: sim.f
+incdir+hdl
hdl/acc_pkg.sv
hdl/acc_wb_if.sv
hdl/mmio_trigger.sv
hdl/hash_sequencer.sv
hdl/result_writer.sv
hdl/acc_control_top.sv
verification/acc_control_assertions.sv
verification/acc_control_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= acc_control_tb
FLIST     ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -sv
SIM_ARGS  ?=
FAIL_MSG  ?= Finished with errors
PASS_MSG  ?= Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)

run: compile
	-./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAIL"; exit 1; \
	elif grep -q "$(PASS_MSG)" $(LOG); then echo "PASS"; \
	else echo "FAIL: no verdict in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verification/acc_control_tb.sv
// ==========================================================================
// Directed testbench for the accelerator control top level. Models memory
// arbiter and compressor, logs accesses and strobes, and checks each job.
// ==========================================================================
`timescale 1ns/100ps
`include "acc_defs.svh"

module acc_control_tb import acc_pkg::*; ();

    // Run length bound from jobs, cycles per job and worst arbiter waits
    localparam int N_JOBS     = 4;
    localparam int JOB_CYCLES = 220;
    localparam int MAX_DELAY  = 3;
    localparam int ACCESSES   = 11;
    localparam int LIMIT      = N_JOBS * (JOB_CYCLES + ACCESSES * (MAX_DELAY + 2)) + 200;

    logic clk = 1'b0;
    logic rst_n, listen_en, rd_en, rd_valid, do_buf_hdr, wr_en, wr_done;
    logic ms_init, ms_enable, cm_is_hashing, cm_update_a_h, cm_update_h0_7;
    logic cm_rst_hash_n, should_save_hash;
    mem_addr_t listen_addr, rd_addr, wr_addr;
    mem_word_t listen_data, wr_data;
    cycle_count_t cm_cycle_count;
    msg_sel_t msg_sel;
    digest_t cm_out;

    // Arbiter model state
    logic [31:0] seed = 32'd32365;
    int max_delay, rd_wait, wr_wait;
    logic rd_armed, wr_armed;

    // Access and strobe logs
    mem_addr_t rd_log[$];
    mem_addr_t wr_addr_log[$];
    mem_word_t wr_data_log[$];
    msg_sel_t msel_log[$];
    int n_rd_cycles, n_buf, n_rst, n_init, n_upd_ah;
    int n_hash, n_ms_en, n_upd2, n_save, done_count;

    acc_control_top i_acc_control_top (.*);

    always #10 clk = ~clk;

    // ======================================================================
    // Helpers
    // ======================================================================
    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
            $display("Finished with errors");
            $fatal(1, "value check failed");
        end
    endtask

    function logic [31:0] lcg_next();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    function int pick_delay();
        if (max_delay == 0) return 0;
        return int'(lcg_next() >> 16) % (max_delay + 1);
    endfunction

    // Distinct word pattern per job and slice
    function automatic logic [31:0] digest_word(input int job, input int i);
        return {8'(job + 1), 8'h3C, 8'(i), 8'hA5};
    endfunction

    function automatic digest_t make_digest(input int job);
        digest_t d;
        for (int i = 0; i < `ACC_DIGEST_WORDS; i++) d[32*i +: 32] = digest_word(job, i);
        return d;
    endfunction

    task automatic cpu_store(input mem_addr_t addr, input mem_word_t data, input logic en);
        @(posedge clk);
        #1;
        listen_en   = en;
        listen_addr = addr;
        listen_data = data;
        @(posedge clk);
        #1;
        listen_en = 1'b0;
    endtask

    task automatic wait_done(input int n);
        while (done_count < n) @(posedge clk);
    endtask

    task automatic clear_logs();
        rd_log.delete();
        wr_addr_log.delete();
        wr_data_log.delete();
        msel_log.delete();
        {n_rd_cycles, n_buf, n_rst, n_init, n_upd_ah, n_hash, n_ms_en, n_upd2, n_save} = '0;
        done_count = 0;
    endtask

    // ======================================================================
    // Memory and arbiter model granting after a random wait
    // ======================================================================
    always @(posedge clk) begin
        #1;
        if (!rd_en) begin
            rd_valid = 1'b0;
            rd_armed = 1'b0;
        end else begin
            // Grant last cycle means a fresh request now
            if (!rd_armed || rd_valid) begin
                rd_armed = 1'b1;
                rd_wait  = pick_delay();
            end else begin
                rd_wait = rd_wait - 1;
            end
            rd_valid = (rd_wait == 0);
        end
        if (!wr_en) begin
            wr_done  = 1'b0;
            wr_armed = 1'b0;
        end else begin
            if (!wr_armed || wr_done) begin
                wr_armed = 1'b1;
                wr_wait  = pick_delay();
            end else begin
                wr_wait = wr_wait - 1;
            end
            wr_done = (wr_wait == 0);
        end
    end

    // Monitor sampling mid cycle
    always @(negedge clk) begin
        if (rst_n) begin
            // Model raises rd_valid only as a grant, so the strobe follows it
            compare("do_buf_hdr", 32'(do_buf_hdr), 32'(rd_valid));
            if (rd_en) n_rd_cycles++;
            if (rd_en && rd_valid) rd_log.push_back(rd_addr);
            if (do_buf_hdr) n_buf++;
            if (wr_en && wr_done) begin
                wr_addr_log.push_back(wr_addr);
                wr_data_log.push_back(wr_data);
                if (wr_addr == `ACC_ACB_ADDR && wr_data == `ACC_STATUS_DONE) done_count++;
            end
            if (!cm_rst_hash_n) n_rst++;
            if (ms_init) begin
                n_init++;
                msel_log.push_back(msg_sel);
            end
            if (cm_update_a_h) n_upd_ah++;
            // Round counter walks 0..63 inside each pass
            if (cm_is_hashing) begin
                compare("cm_cycle_count", 32'(cm_cycle_count), 32'(n_hash % `ACC_HASH_CYCLES));
                n_hash++;
            end
            if (ms_enable) n_ms_en++;
            if (cm_update_h0_7) n_upd2++;
            if (should_save_hash) n_save++;
        end
    end

    // ======================================================================
    // Checks over the logs
    // ======================================================================
    task automatic check_strobes(input int jobs);
        compare("read count", 32'(rd_log.size()), 32'(2 * jobs));
        for (int k = 0; k < rd_log.size(); k++) begin
            compare("rd_addr", 32'(rd_log[k]),
                    (k % 2 == 0) ? 32'(`ACC_MSG1_ADDR) : 32'(`ACC_MSG2_ADDR));
        end
        compare("do_buf_hdr pulses", 32'(n_buf), 32'(2 * jobs));
        compare("cm_rst_hash_n pulses", 32'(n_rst), 32'((`ACC_HASH_PASSES - 1) * jobs));
        compare("ms_init pulses", 32'(n_init), 32'(`ACC_HASH_PASSES * jobs));
        compare("cm_update_a_h pulses", 32'(n_upd_ah), 32'(`ACC_HASH_PASSES * jobs));
        compare("cm_is_hashing cycles", 32'(n_hash),
                32'(`ACC_HASH_PASSES * `ACC_HASH_CYCLES * jobs));
        compare("ms_enable cycles", 32'(n_ms_en),
                32'(`ACC_HASH_PASSES * `ACC_HASH_CYCLES * jobs));
        compare("cm_update_h0_7 pulses", 32'(n_upd2), 32'(`ACC_HASH_PASSES * jobs));
        compare("should_save_hash pulses", 32'(n_save), 32'(`ACC_HASH_PASSES * jobs));
        for (int k = 0; k < msel_log.size(); k++) begin
            compare("msg_sel", 32'(msel_log[k]), 32'(k % `ACC_HASH_PASSES));
        end
    endtask

    // Busy write, eight slices and done write from log entry base
    task automatic check_job_writes(input int base, input int job);
        compare("wr_addr", 32'(wr_addr_log[base]), 32'(`ACC_ACB_ADDR));
        compare("wr_data", wr_data_log[base], `ACC_STATUS_BUSY);
        for (int i = 0; i < `ACC_DIGEST_WORDS; i++) begin
            compare("wr_addr", 32'(wr_addr_log[base + 1 + i]),
                    32'(`ACC_H0_ADDR + i * `ACC_H_ADDR_STEP));
            compare("wr_data", wr_data_log[base + 1 + i], digest_word(job, i));
        end
        compare("wr_addr", 32'(wr_addr_log[base + 9]), 32'(`ACC_ACB_ADDR));
        compare("wr_data", wr_data_log[base + 9], `ACC_STATUS_DONE);
    endtask

    // ======================================================================
    // Tests
    // ======================================================================
    task automatic test_reset_values();
        clear_logs();
        compare("rd_en", 32'(rd_en), 32'd0);
        compare("wr_en", 32'(wr_en), 32'd0);
        compare("do_buf_hdr", 32'(do_buf_hdr), 32'd0);
        compare("ms_init", 32'(ms_init), 32'd0);
        compare("ms_enable", 32'(ms_enable), 32'd0);
        compare("cm_is_hashing", 32'(cm_is_hashing), 32'd0);
        compare("cm_update_a_h", 32'(cm_update_a_h), 32'd0);
        compare("cm_update_h0_7", 32'(cm_update_h0_7), 32'd0);
        compare("should_save_hash", 32'(should_save_hash), 32'd0);
        compare("cm_rst_hash_n", 32'(cm_rst_hash_n), 32'd1);
        compare("msg_sel", 32'(msg_sel), 32'd0);
        compare("cm_cycle_count", 32'(cm_cycle_count), 32'd0);
        repeat (10) @(posedge clk);
        compare("rd_en cycles", 32'(n_rd_cycles), 32'd0);
        compare("write count", 32'(wr_addr_log.size()), 32'd0);
    endtask

    task automatic test_ignored_stores();
        clear_logs();
        cpu_store(16'h5004, 32'h1, 1'b1);
        cpu_store(`ACC_ACB_ADDR, 32'h2, 1'b1);
        cpu_store(`ACC_ACB_ADDR, 32'h1, 1'b0);
        repeat (10) @(posedge clk);
        compare("rd_en cycles", 32'(n_rd_cycles), 32'd0);
        compare("write count", 32'(wr_addr_log.size()), 32'd0);
    endtask

    task automatic test_single_job(input int delay, input int job);
        clear_logs();
        max_delay = delay;
        @(posedge clk);
        #1;
        cm_out = make_digest(job);
        cpu_store(`ACC_ACB_ADDR, 32'h1, 1'b1);
        wait_done(1);
        check_strobes(1);
        compare("write count", 32'(wr_addr_log.size()), 32'd10);
        check_job_writes(0, job);
    endtask

    task automatic test_back_to_back(input int job);
        clear_logs();
        max_delay = MAX_DELAY;
        @(posedge clk);
        #1;
        cm_out = make_digest(job);
        cpu_store(`ACC_ACB_ADDR, 32'h1, 1'b1);
        // Second trigger lands while the first job is running
        while (rd_log.size() == 0) @(posedge clk);
        cpu_store(`ACC_ACB_ADDR, 32'h3, 1'b1);
        wait_done(1);
        // First digest already captured by the writer
        @(posedge clk);
        #1;
        cm_out = make_digest(job + 1);
        wait_done(2);
        check_strobes(2);
        compare("write count", 32'(wr_addr_log.size()), 32'd20);
        check_job_writes(0, job);
        check_job_writes(10, job + 1);
    endtask

    // ======================================================================
    // Main sequence and watchdog
    // ======================================================================
    initial begin
        rst_n       = 1'b0;
        listen_en   = 1'b0;
        listen_addr = '0;
        listen_data = '0;
        rd_valid    = 1'b0;
        wr_done     = 1'b0;
        rd_armed    = 1'b0;
        wr_armed    = 1'b0;
        cm_out      = '0;
        max_delay   = 0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_reset_values();
        test_ignored_stores();
        test_single_job(0, 0);
        test_single_job(MAX_DELAY, 1);
        test_back_to_back(2);
        @(posedge clk);
        if (i_acc_control_top.i_acc_control_assertions.fail_count != 0) begin
            $display("assertion failures: %0d",
                     i_acc_control_top.i_acc_control_assertions.fail_count);
            $display("Finished with errors");
            $fatal(1, "assertions failed");
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

    initial begin
        repeat (LIMIT) @(posedge clk);
        $display("timeout: tests did not finish within %0d cycles", LIMIT);
        $display("Finished with errors");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: verification/acc_control_assertions.sv
// ==========================================================================
// Concurrent checks on the control top level's ports, bound into the DUT.
// ==========================================================================
`timescale 1ns/100ps

module acc_control_assertions import acc_pkg::*; (
    input logic      clk,
    input logic      rst_n,
    input logic      rd_en,
    input mem_addr_t rd_addr,
    input logic      rd_valid,
    input logic      wr_en,
    input mem_addr_t wr_addr,
    input mem_word_t wr_data,
    input logic      wr_done,
    input logic      cm_is_hashing,
    input logic      cm_update_a_h,
    input logic      cm_update_h0_7,
    input msg_sel_t  msg_sel
);

    int fail_count = 0;

    // Read request holds until granted
    rd_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rd_en && !rd_valid |=> rd_en && $stable(rd_addr))
        else begin
            $error("rd_addr or rd_en changed while waiting for rd_valid");
            fail_count++;
        end

    // Write request holds until done
    wr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en && !wr_done |=> wr_en && $stable(wr_addr) && $stable(wr_data))
        else begin
            $error("write port changed while waiting for wr_done");
            fail_count++;
        end

    // Rounds never overlap a state update
    no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
        !(cm_is_hashing && (cm_update_a_h || cm_update_h0_7)))
        else begin
            $error("cm_is_hashing high together with an update strobe");
            fail_count++;
        end

    sel_range: assert property (@(posedge clk) disable iff (!rst_n) msg_sel != 2'd3)
        else begin
            $error("msg_sel reached 3");
            fail_count++;
        end

endmodule

bind acc_control_top acc_control_assertions i_acc_control_assertions (
    .clk            (clk),
    .rst_n          (rst_n),
    .rd_en          (rd_en),
    .rd_addr        (rd_addr),
    .rd_valid       (rd_valid),
    .wr_en          (wr_en),
    .wr_addr        (wr_addr),
    .wr_data        (wr_data),
    .wr_done        (wr_done),
    .cm_is_hashing  (cm_is_hashing),
    .cm_update_a_h  (cm_update_a_h),
    .cm_update_h0_7 (cm_update_h0_7),
    .msg_sel        (msg_sel)
);

// File: hdl/acc_control_top.sv
// ==========================================================================
// Accelerator control unit top level. Connects trigger, sequencer and
// result writer, exposing the memory ports and compressor strobes.
// ==========================================================================
`timescale 1ns/100ps

module acc_control_top import acc_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    // CPU store bus
    input  logic            listen_en,
    input  mem_addr_t       listen_addr,
    input  mem_word_t       listen_data,
    // Arbitrated read port
    output logic            rd_en,
    output mem_addr_t       rd_addr,
    input  logic            rd_valid,
    output logic            do_buf_hdr,
    // Arbitrated write port
    output logic            wr_en,
    output mem_addr_t       wr_addr,
    output mem_word_t       wr_data,
    input  logic            wr_done,
    // Scheduler and compressor
    output logic            ms_init,
    output logic            ms_enable,
    output logic            cm_is_hashing,
    output logic            cm_update_a_h,
    output logic            cm_update_h0_7,
    output logic            cm_rst_hash_n,
    output cycle_count_t    cm_cycle_count,
    output logic            should_save_hash,
    output msg_sel_t        msg_sel,
    input  digest_t         cm_out
);

    // Start link
    logic start_valid;
    logic start_ready;

    // Write-back link
    acc_wb_if wb_if ();

    mmio_trigger i_mmio_trigger (
        .clk         (clk),
        .rst_n       (rst_n),
        .listen_en   (listen_en),
        .listen_addr (listen_addr),
        .listen_data (listen_data),
        .start_valid (start_valid),
        .start_ready (start_ready)
    );

    hash_sequencer i_hash_sequencer (
        .clk              (clk),
        .rst_n            (rst_n),
        .start_valid      (start_valid),
        .start_ready      (start_ready),
        .rd_en            (rd_en),
        .rd_addr          (rd_addr),
        .rd_valid         (rd_valid),
        .do_buf_hdr       (do_buf_hdr),
        .ms_init          (ms_init),
        .ms_enable        (ms_enable),
        .cm_is_hashing    (cm_is_hashing),
        .cm_update_a_h    (cm_update_a_h),
        .cm_update_h0_7   (cm_update_h0_7),
        .cm_rst_hash_n    (cm_rst_hash_n),
        .cm_cycle_count   (cm_cycle_count),
        .should_save_hash (should_save_hash),
        .msg_sel          (msg_sel),
        .cm_out           (cm_out),
        .wb               (wb_if.source)
    );

    result_writer i_result_writer (
        .clk     (clk),
        .rst_n   (rst_n),
        .wb      (wb_if.sink),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .wr_done (wr_done)
    );

endmodule

// File: hdl/result_writer.sv
// ==========================================================================
// Takes busy and digest items from the sequencer and writes them out word
// by word through the arbitrated write port, one wr_done per word.
// ==========================================================================
`timescale 1ns/100ps
`include "acc_defs.svh"

module result_writer import acc_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    // Items from the sequencer
    acc_wb_if.sink      wb,
    // Arbitrated write port
    output logic        wr_en,
    output mem_addr_t   wr_addr,
    output mem_word_t   wr_data,
    input  logic        wr_done
);

    // Word index 0..7 for digest slices, DIGEST_WORDS for the status word
    localparam int IDX_W = $clog2(`ACC_DIGEST_WORDS + 1);
    localparam logic [IDX_W-1:0] STATUS_IDX = IDX_W'(`ACC_DIGEST_WORDS);

    wr_state_t          state;
    logic [IDX_W-1:0]   word_idx;
    logic               is_digest_q;
    digest_t            digest_q;
    logic               take;

    // Only accept while idle
    assign wb.ready = (state == WR_IDLE);
    assign take     = wb.valid && wb.ready;

    // ======================================================================
    // Control state
    // ======================================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= WR_IDLE;
            word_idx <= '0;
        end else if (take) begin
            state <= WR_WRITE;
            // Busy item goes straight to the status word
            word_idx <= wb.is_digest ? '0 : STATUS_IDX;
        end else if (state == WR_WRITE && wr_done) begin
            if (word_idx == STATUS_IDX) state <= WR_IDLE;
            else                        word_idx <= word_idx + 1'b1;
        end
    end

    // Item payload, frees the sequencer for the next job
    always_ff @(posedge clk) begin
        if (take) begin
            is_digest_q <= wb.is_digest;
            digest_q    <= wb.digest;
        end
    end

    // ======================================================================
    // Write port
    // ======================================================================
    always_comb begin
        wr_en = (state == WR_WRITE);
        if (word_idx == STATUS_IDX) begin
            wr_addr = `ACC_ACB_ADDR;
            wr_data = is_digest_q ? `ACC_STATUS_DONE : `ACC_STATUS_BUSY;
        end else begin
            wr_addr = mem_addr_t'(`ACC_H0_ADDR + word_idx * `ACC_H_ADDR_STEP);
            wr_data = digest_q[word_idx[2:0]*`ACC_WORD_W +: `ACC_WORD_W];
        end
    end

endmodule

// File: hdl/hash_sequencer.sv
// ==========================================================================
// Runs one hashing job: both header fetches, three compression passes and
// the hand-off of busy status and final digest to the result writer.
// ==========================================================================
`timescale 1ns/100ps
`include "acc_defs.svh"

module hash_sequencer import acc_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    // Start link from the trigger
    input  logic            start_valid,
    output logic            start_ready,
    // Arbitrated read port
    output logic            rd_en,
    output mem_addr_t       rd_addr,
    input  logic            rd_valid,
    output logic            do_buf_hdr,
    // Scheduler and compressor strobes
    output logic            ms_init,
    output logic            ms_enable,
    output logic            cm_is_hashing,
    output logic            cm_update_a_h,
    output logic            cm_update_h0_7,
    output logic            cm_rst_hash_n,
    output cycle_count_t    cm_cycle_count,
    output logic            should_save_hash,
    output msg_sel_t        msg_sel,
    input  digest_t         cm_out,
    // Write-back items
    acc_wb_if.source        wb
);

    seq_state_t     state, next_state;
    cycle_count_t   cycle_cnt;
    msg_sel_t       pass_cnt;
    logic           hash_last;

    // Terminal round count reached
    assign hash_last = (cycle_cnt == cycle_count_t'(`ACC_HASH_CYCLES));

    // Digest is only looked at by the writer on a digest item
    assign wb.digest = cm_out;

    // ======================================================================
    // Next state and strobes
    // ======================================================================
    always_comb begin
        next_state       = state;
        start_ready      = 1'b0;
        rd_en            = 1'b0;
        rd_addr          = '0;
        do_buf_hdr       = 1'b0;
        ms_init          = 1'b0;
        ms_enable        = 1'b0;
        cm_is_hashing    = 1'b0;
        cm_update_a_h    = 1'b0;
        cm_update_h0_7   = 1'b0;
        cm_rst_hash_n    = 1'b1;
        should_save_hash = 1'b0;
        wb.valid         = 1'b0;
        wb.is_digest     = 1'b0;
        case (state)
            SEQ_IDLE: begin
                start_ready = 1'b1;
                if (start_valid) next_state = SEQ_READ1;
            end
            SEQ_READ1: begin
                rd_en   = 1'b1;
                rd_addr = `ACC_MSG1_ADDR;
                // Buffer strobe lines up with the arbiter grant
                if (rd_valid) begin
                    do_buf_hdr = 1'b1;
                    next_state = SEQ_BUSY;
                end
            end
            SEQ_BUSY: begin
                wb.valid = 1'b1;
                if (wb.ready) next_state = SEQ_INIT;
            end
            SEQ_INIT: begin
                cm_rst_hash_n = 1'b0;
                next_state    = SEQ_UPD1;
            end
            // [A:H] <- [H0:H7]
            SEQ_UPD1: begin
                cm_update_a_h = 1'b1;
                ms_init       = 1'b1;
                next_state    = SEQ_HASH;
            end
            SEQ_HASH: begin
                if (hash_last) begin
                    next_state = SEQ_UPD2;
                end else begin
                    cm_is_hashing = 1'b1;
                    ms_enable     = 1'b1;
                end
            end
            // [H0:H7] <- [H0:H7] + [A:H]
            SEQ_UPD2: begin
                cm_update_h0_7 = 1'b1;
                next_state     = SEQ_SAVE;
            end
            SEQ_SAVE: begin
                should_save_hash = 1'b1;
                if (pass_cnt == msg_sel_t'(`ACC_HASH_PASSES - 1)) next_state = SEQ_DIGEST;
                else if (pass_cnt == 2'd0)                        next_state = SEQ_READ2;
                else                                              next_state = SEQ_INIT;
            end
            SEQ_READ2: begin
                rd_en   = 1'b1;
                rd_addr = `ACC_MSG2_ADDR;
                // Pass 1 chains into UPD1 with no compressor reset
                if (rd_valid) begin
                    do_buf_hdr = 1'b1;
                    next_state = SEQ_UPD1;
                end
            end
            SEQ_DIGEST: begin
                wb.valid     = 1'b1;
                wb.is_digest = 1'b1;
                if (wb.ready) next_state = SEQ_IDLE;
            end
            default: next_state = SEQ_IDLE;
        endcase
    end

    // ======================================================================
    // State, round counter and pass counter
    // ======================================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= SEQ_IDLE;
            cycle_cnt <= '0;
            pass_cnt  <= '0;
        end else begin
            state <= next_state;
            // Count rounds, clear at the terminal count
            if (state == SEQ_HASH) cycle_cnt <= hash_last ? '0 : cycle_cnt + 1'b1;
            // Next pass after each save except the last
            if (state == SEQ_SAVE && next_state != SEQ_DIGEST) pass_cnt <= pass_cnt + 1'b1;
            // Back to pass 0 once the digest is handed off
            if (state == SEQ_DIGEST && wb.ready) pass_cnt <= '0;
        end
    end

    assign cm_cycle_count = cycle_cnt;
    assign msg_sel        = pass_cnt;

endmodule

// File: hdl/mmio_trigger.sv
// ==========================================================================
// Snoops CPU stores for a write of the status word with the valid bit set
// and holds one start request until the sequencer takes it.
// ==========================================================================
`timescale 1ns/100ps
`include "acc_defs.svh"

module mmio_trigger import acc_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    // CPU store bus
    input  logic        listen_en,
    input  mem_addr_t   listen_addr,
    input  mem_word_t   listen_data,
    // Start request towards the sequencer
    output logic        start_valid,
    input  logic        start_ready
);

    logic hit;
    logic pending;

    // Store to the status word with bit 0 set
    assign hit = listen_en && (listen_addr == `ACC_ACB_ADDR) && listen_data[0];

    // ======================================================================
    // Pending start request
    // ======================================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending <= 1'b0;
        end else if (hit) begin
            // New store wins over a consume in the same cycle,
            // a store on top of a pending request just merges
            pending <= 1'b1;
        end else if (pending && start_ready) begin
            pending <= 1'b0;
        end
    end

    assign start_valid = pending;

endmodule

// File: hdl/acc_wb_if.sv
// ==========================================================================
// Write-back link from the sequencer to the result writer. One item is
// either the busy status or a final digest, moved by valid and ready.
// ==========================================================================
`timescale 1ns/100ps

interface acc_wb_if import acc_pkg::*; ();

    logic       valid;
    logic       ready;
    // Low for the busy status, high for a digest
    logic       is_digest;
    digest_t    digest;

    // Sequencer side
    modport source (output valid, output is_digest, output digest, input ready);

    // Writer side
    modport sink (input valid, input is_digest, input digest, output ready);

endinterface

// File: hdl/acc_pkg.sv
// ==========================================================================
// Shared vector types and FSM encodings of the accelerator control unit.
// Imported by each RTL module and interface that uses them.
// ==========================================================================
`include "acc_defs.svh"

package acc_pkg;

    // Memory address and word
    typedef logic [`ACC_ADDR_W-1:0]     mem_addr_t;
    typedef logic [`ACC_WORD_W-1:0]     mem_word_t;

    // Full compressor output
    typedef logic [`ACC_DIGEST_W-1:0]   digest_t;

    // Round counter, one bit wider to reach the terminal count
    typedef logic [$clog2(`ACC_HASH_CYCLES):0] cycle_count_t;

    // Pass index, also the header half select
    typedef logic [1:0]                 msg_sel_t;

    // Sequencer states
    typedef enum logic [3:0] {
        SEQ_IDLE, SEQ_READ1, SEQ_BUSY, SEQ_INIT, SEQ_UPD1,
        SEQ_HASH, SEQ_UPD2, SEQ_SAVE, SEQ_READ2, SEQ_DIGEST
    } seq_state_t;

    // Writer states
    typedef enum logic {WR_IDLE, WR_WRITE} wr_state_t;

endpackage

// File: hdl/acc_defs.svh
// ==========================================================================
// Memory map, status words, widths and pass counts of the accelerator
// control unit. Included by every RTL file that needs one of these values.
// ==========================================================================
`ifndef ACC_DEFS_SVH
`define ACC_DEFS_SVH

// Bus widths
`define ACC_ADDR_W          16
`define ACC_LISTEN_DATA_W   32
// Write words share the width of CPU stores
`define ACC_WORD_W          `ACC_LISTEN_DATA_W
`define ACC_DIGEST_W        256
`define ACC_DIGEST_WORDS    8

// Accelerator communication block
`define ACC_ACB_ADDR        16'h5000
`define ACC_H0_ADDR         16'h5008
`define ACC_H_ADDR_STEP     32

// Header halves in the host communication block
`define ACC_MSG1_ADDR       16'h1010
`define ACC_MSG2_ADDR       16'h0FD0

// Status word values
`define ACC_STATUS_BUSY     32'd5
`define ACC_STATUS_DONE     32'd2

// Compression schedule
`define ACC_HASH_CYCLES     64
`define ACC_HASH_PASSES     3

`endif
